/* filelist.f */
hw/axi4l_pkg.sv
hw/axi4l_chan_slice.sv
hw/axi4l_reg_slice.sv
hw/axi4l_reg_file.sv
hw/axi4l_reg_ctrl.sv
hw/axi4l_reg_top.sv
dv/axi4l_clk_gen.sv
dv/axi4l_reg_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
TOP       := axi4l_reg_tb
FILELIST  := filelist.f
LOG       := sim.log
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	$(SIM) 2>&1 | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* dv/axi4l_reg_tb.sv */
`timescale 1ns/1ps

module axi4l_reg_tb;

    localparam int NUM_REGS       = 8;
    localparam int TIMEOUT_CYCLES = 4000;   // about ten times the summed test length.

    logic                 aclk;
    logic                 reset;
    axi4l_pkg::axi4l_aw_t s_aw;
    logic                 s_aw_valid;
    logic                 s_aw_ready;
    axi4l_pkg::axi4l_w_t  s_w;
    logic                 s_w_valid;
    logic                 s_w_ready;
    axi4l_pkg::axi4l_b_t  s_b;
    logic                 s_b_valid;
    logic                 s_b_ready;
    axi4l_pkg::axi4l_ar_t s_ar;
    logic                 s_ar_valid;
    logic                 s_ar_ready;
    axi4l_pkg::axi4l_r_t  s_r;
    logic                 s_r_valid;
    logic                 s_r_ready;

    axi4l_pkg::axi4l_data_t model [NUM_REGS];   // expected register contents.
    int checks;
    int errors;
    int cycle_count;
    int b_count;
    int r_count;

    axi4l_clk_gen u_clk_gen (
        .aclk  (aclk),
        .reset (reset)
    );

    axi4l_reg_top #(
        .SLICE_MODE (axi4l_pkg::SLICE_FULL),
        .NUM_REGS   (NUM_REGS)
    ) u_dut (
        .aclk       (aclk),
        .reset      (reset),
        .s_aw       (s_aw),
        .s_aw_valid (s_aw_valid),
        .s_aw_ready (s_aw_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .s_b        (s_b),
        .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready)
    );

    ////////////////////////////////////////////////////////////////////////////
    // handshake counters and watchdog

    always @(posedge aclk) begin
        if (s_b_valid && s_b_ready) b_count <= b_count + 1;
        if (s_r_valid && s_r_ready) r_count <= r_count + 1;
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run exceeded %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic axi4l_pkg::axi4l_resp_t model_write(input axi4l_pkg::axi4l_addr_t addr,
                                                          input axi4l_pkg::axi4l_data_t data,
                                                          input axi4l_pkg::axi4l_strb_t strb);
        int idx;
        idx = int'(addr[9:2]);
        if (addr[31:10] != '0 || idx >= NUM_REGS || idx == 0) return axi4l_pkg::RESP_SLVERR;
        for (int j = 0; j < 4; j++) begin
            if (strb[j]) model[idx][j*8 +: 8] = data[j*8 +: 8];
        end
        return axi4l_pkg::RESP_OKAY;
    endfunction

    function automatic axi4l_pkg::axi4l_resp_t model_read(input axi4l_pkg::axi4l_addr_t addr,
                                                         output axi4l_pkg::axi4l_data_t data);
        int idx;
        idx  = int'(addr[9:2]);
        data = '0;
        if (addr[31:10] != '0 || idx >= NUM_REGS) return axi4l_pkg::RESP_SLVERR;
        data = model[idx];
        return axi4l_pkg::RESP_OKAY;
    endfunction

    function automatic axi4l_pkg::axi4l_addr_t addr_of(input int idx);
        return axi4l_pkg::axi4l_addr_t'(idx * 4);
    endfunction

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %0s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        $display("test %0s: %0s (%0d errors)", name,
                 (errors == err_start) ? "passed" : "failed", errors - err_start);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // channel drivers, all on the falling edge

    task automatic drive_aw(input axi4l_pkg::axi4l_addr_t addr, input int delay);
        repeat (delay + 1) @(negedge aclk);
        s_aw.addr  = addr;
        s_aw.prot  = 3'b000;
        s_aw_valid = 1'b1;
        while (s_aw_ready !== 1'b1) @(negedge aclk);
        @(negedge aclk);
        s_aw_valid = 1'b0;
    endtask

    task automatic drive_w(input axi4l_pkg::axi4l_data_t data, input axi4l_pkg::axi4l_strb_t strb,
                           input int delay);
        repeat (delay + 1) @(negedge aclk);
        s_w.data  = data;
        s_w.strb  = strb;
        s_w_valid = 1'b1;
        while (s_w_ready !== 1'b1) @(negedge aclk);
        @(negedge aclk);
        s_w_valid = 1'b0;
    endtask

    task automatic drive_ar(input axi4l_pkg::axi4l_addr_t addr);
        @(negedge aclk);
        s_ar.addr  = addr;
        s_ar.prot  = 3'b000;
        s_ar_valid = 1'b1;
        while (s_ar_ready !== 1'b1) @(negedge aclk);
        @(negedge aclk);
        s_ar_valid = 1'b0;
    endtask

    // holds bready low for stall cycles once bvalid shows, then accepts.
    task automatic take_b(input int stall, output axi4l_pkg::axi4l_resp_t resp);
        @(negedge aclk);
        while (s_b_valid !== 1'b1) @(negedge aclk);
        resp = s_b.resp;
        repeat (stall) begin
            @(negedge aclk);
            checks++;
            assert (s_b_valid === 1'b1) else begin
                $display("error at %0t: bvalid dropped before bready", $time);
                errors++;
            end
            expect_value("s_b.resp", 32'(s_b.resp), 32'(resp));
        end
        s_b_ready = 1'b1;
        @(negedge aclk);
        s_b_ready = 1'b0;
    endtask

    task automatic take_r(input int stall, output axi4l_pkg::axi4l_r_t r);
        @(negedge aclk);
        while (s_r_valid !== 1'b1) @(negedge aclk);
        r = s_r;
        repeat (stall) begin
            @(negedge aclk);
            checks++;
            assert (s_r_valid === 1'b1) else begin
                $display("error at %0t: rvalid dropped before rready", $time);
                errors++;
            end
            expect_value("s_r.data", s_r.data, r.data);
            expect_value("s_r.resp", 32'(s_r.resp), 32'(r.resp));
        end
        s_r_ready = 1'b1;
        @(negedge aclk);
        s_r_ready = 1'b0;
    endtask

    task automatic issue_write(input axi4l_pkg::axi4l_addr_t addr,
                               input axi4l_pkg::axi4l_data_t data,
                               input axi4l_pkg::axi4l_strb_t strb, input int aw_delay,
                               input int w_delay);
        fork
            drive_aw(addr, aw_delay);
            drive_w(data, strb, w_delay);
        join
    endtask

    task automatic write_reg(input axi4l_pkg::axi4l_addr_t addr,
                             input axi4l_pkg::axi4l_data_t data,
                             input axi4l_pkg::axi4l_strb_t strb, input int aw_delay,
                             input int w_delay, input int stall);
        axi4l_pkg::axi4l_resp_t resp;
        axi4l_pkg::axi4l_resp_t exp_resp;
        issue_write(addr, data, strb, aw_delay, w_delay);
        take_b(stall, resp);
        exp_resp = model_write(addr, data, strb);
        expect_value("s_b.resp", 32'(resp), 32'(exp_resp));
    endtask

    task automatic read_reg(input axi4l_pkg::axi4l_addr_t addr, input int stall);
        axi4l_pkg::axi4l_r_t    r;
        axi4l_pkg::axi4l_data_t exp_data;
        axi4l_pkg::axi4l_resp_t exp_resp;
        drive_ar(addr);
        take_r(stall, r);
        exp_resp = model_read(addr, exp_data);
        expect_value("s_r.resp", 32'(r.resp), 32'(exp_resp));
        expect_value("s_r.data", r.data, exp_data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests

    task automatic check_idle();
        checks++;
        assert (s_b_valid === 1'b0 && s_r_valid === 1'b0) else begin
            $display("error at %0t: response valid raised with no request", $time);
            errors++;
        end
    endtask

    task automatic test_reset_state();
        int err_start;
        err_start = errors;
        @(posedge aclk);
        while (reset) begin
            @(negedge aclk);
            check_idle();
            @(posedge aclk);   // reset moves on the falling edge.
        end
        repeat (4) begin
            @(negedge aclk);
            check_idle();
        end
        read_reg(addr_of(0), 0);   // id register.
        finish_test("reset_state", err_start);
    endtask

    task automatic test_full_writes();
        int err_start;
        err_start = errors;
        for (int i = 1; i < NUM_REGS; i++) begin
            write_reg(addr_of(i), $urandom, 4'hf, 0, 0, 0);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(addr_of(i), 0);
        end
        finish_test("full_writes", err_start);
    endtask

    task automatic test_partial_strobes();
        int err_start;
        int idx;
        axi4l_pkg::axi4l_addr_t addr;
        axi4l_pkg::axi4l_strb_t strb;
        err_start = errors;
        for (int k = 0; k < 8; k++) begin
            idx  = $urandom_range(NUM_REGS - 1, 1);
            addr = addr_of(idx) + axi4l_pkg::axi4l_addr_t'(k % 4);   // byte offset ignored.
            strb = axi4l_pkg::axi4l_strb_t'($urandom_range(14, 1));
            if (k % 2 == 0) begin
                write_reg(addr, $urandom, strb, 0, $urandom_range(5, 2), 0);   // aw leads.
            end else begin
                write_reg(addr, $urandom, strb, $urandom_range(5, 2), 0, 0);   // w leads.
            end
            read_reg(addr_of(idx), 0);
        end
        finish_test("partial_strobes", err_start);
    endtask

    task automatic test_error_responses();
        int err_start;
        err_start = errors;
        write_reg(addr_of(0), 32'hdead_beef, 4'hf, 0, 0, 0);
        read_reg(addr_of(0), 0);
        write_reg(addr_of(NUM_REGS), 32'h1234_5678, 4'hf, 0, 0, 0);
        read_reg(addr_of(NUM_REGS), 0);
        write_reg(32'h0000_1004, 32'h5a5a_5a5a, 4'hf, 0, 0, 0);   // upper bits set.
        read_reg(32'h0000_1004, 0);
        read_reg(addr_of(1), 0);
        finish_test("error_responses", err_start);
    endtask

    task automatic test_back_pressure();
        int err_start;
        int b_start;
        int r_start;
        int idx;
        axi4l_pkg::axi4l_data_t data [3];
        axi4l_pkg::axi4l_strb_t strb [3];
        axi4l_pkg::axi4l_resp_t resp;
        axi4l_pkg::axi4l_resp_t exp_resp;
        err_start = errors;
        b_start   = b_count;
        r_start   = r_count;
        for (int k = 0; k < 6; k++) begin
            idx = $urandom_range(NUM_REGS - 1, 1);
            write_reg(addr_of(idx), $urandom, 4'hf, 0, 0, $urandom_range(10, 0));
            read_reg(addr_of(idx), $urandom_range(10, 0));
        end
        // three writes queue up behind a stalled B channel.
        idx     = $urandom_range(NUM_REGS - 1, 1);
        strb[0] = 4'b0011;
        strb[1] = 4'b0110;
        strb[2] = 4'b1100;
        for (int k = 0; k < 3; k++) begin
            data[k] = $urandom;
            issue_write(addr_of(idx), data[k], strb[k], 0, 0);
        end
        for (int k = 0; k < 3; k++) begin
            take_b($urandom_range(10, 0), resp);
            exp_resp = model_write(addr_of(idx), data[k], strb[k]);
            expect_value("s_b.resp", 32'(resp), 32'(exp_resp));
        end
        read_reg(addr_of(idx), $urandom_range(10, 0));
        repeat (4) begin
            @(negedge aclk);
            check_idle();
        end
        expect_value("b handshake count", 32'(b_count - b_start), 32'd9);
        expect_value("r handshake count", 32'(r_count - r_start), 32'd7);
        finish_test("back_pressure", err_start);
    endtask

    initial begin
        s_aw        = '0;
        s_aw_valid  = 1'b0;
        s_w         = '0;
        s_w_valid   = 1'b0;
        s_b_ready   = 1'b0;
        s_ar        = '0;
        s_ar_valid  = 1'b0;
        s_r_ready   = 1'b0;
        checks      = 0;
        errors      = 0;
        cycle_count = 0;
        b_count     = 0;
        r_count     = 0;
        void'($urandom(32'h1c980ed6));
        model[0] = axi4l_pkg::REG_ID_VALUE;
        for (int i = 1; i < NUM_REGS; i++) begin
            model[i] = '0;
        end

        test_reset_state();
        test_full_writes();
        test_partial_strobes();
        test_error_responses();
        test_back_pressure();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/axi4l_clk_gen.sv */
`timescale 1ns/1ps

module axi4l_clk_gen #(
    parameter int HALF_PERIOD  = 4,   // 8 ns clock.
    parameter int RESET_CYCLES = 5
) (
    output logic aclk,
    output logic reset
);

    initial begin
        aclk = 1'b0;
        forever #(HALF_PERIOD) aclk = ~aclk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;   // released away from the sampling edge.
    end

endmodule

/* hw/axi4l_reg_top.sv */
`timescale 1ns/1ps

module axi4l_reg_top #(
    parameter axi4l_pkg::axi4l_slice_mode_t SLICE_MODE = axi4l_pkg::SLICE_FULL,
    parameter int                           NUM_REGS   = 8
) (
    input  logic                 aclk,
    input  logic                 reset,
    input  axi4l_pkg::axi4l_aw_t s_aw,
    input  logic                 s_aw_valid,
    output logic                 s_aw_ready,
    input  axi4l_pkg::axi4l_w_t  s_w,
    input  logic                 s_w_valid,
    output logic                 s_w_ready,
    output axi4l_pkg::axi4l_b_t  s_b,
    output logic                 s_b_valid,
    input  logic                 s_b_ready,
    input  axi4l_pkg::axi4l_ar_t s_ar,
    input  logic                 s_ar_valid,
    output logic                 s_ar_ready,
    output axi4l_pkg::axi4l_r_t  s_r,
    output logic                 s_r_valid,
    input  logic                 s_r_ready
);

    logic                   periph_reset;
    axi4l_pkg::axi4l_aw_t   aw;
    logic                   aw_valid;
    logic                   aw_ready;
    axi4l_pkg::axi4l_w_t    w;
    logic                   w_valid;
    logic                   w_ready;
    axi4l_pkg::axi4l_b_t    b;
    logic                   b_valid;
    logic                   b_ready;
    axi4l_pkg::axi4l_ar_t   ar;
    logic                   ar_valid;
    logic                   ar_ready;
    axi4l_pkg::axi4l_r_t    r;
    logic                   r_valid;
    logic                   r_ready;
    logic                   wr_en;
    axi4l_pkg::reg_index_t  wr_index;
    axi4l_pkg::axi4l_data_t wr_data;
    axi4l_pkg::axi4l_strb_t wr_strb;
    axi4l_pkg::reg_index_t  rd_index;
    axi4l_pkg::axi4l_data_t rd_data;

    axi4l_reg_slice #(
        .SLICE_MODE (SLICE_MODE)
    ) u_slice (
        .aclk         (aclk),
        .reset        (reset),
        .periph_reset (periph_reset),
        .s_aw         (s_aw),
        .s_aw_valid   (s_aw_valid),
        .s_aw_ready   (s_aw_ready),
        .s_w          (s_w),
        .s_w_valid    (s_w_valid),
        .s_w_ready    (s_w_ready),
        .s_b          (s_b),
        .s_b_valid    (s_b_valid),
        .s_b_ready    (s_b_ready),
        .s_ar         (s_ar),
        .s_ar_valid   (s_ar_valid),
        .s_ar_ready   (s_ar_ready),
        .s_r          (s_r),
        .s_r_valid    (s_r_valid),
        .s_r_ready    (s_r_ready),
        .m_aw         (aw),
        .m_aw_valid   (aw_valid),
        .m_aw_ready   (aw_ready),
        .m_w          (w),
        .m_w_valid    (w_valid),
        .m_w_ready    (w_ready),
        .m_b          (b),
        .m_b_valid    (b_valid),
        .m_b_ready    (b_ready),
        .m_ar         (ar),
        .m_ar_valid   (ar_valid),
        .m_ar_ready   (ar_ready),
        .m_r          (r),
        .m_r_valid    (r_valid),
        .m_r_ready    (r_ready)
    );

    axi4l_reg_ctrl #(
        .NUM_REGS (NUM_REGS)
    ) u_ctrl (
        .aclk     (aclk),
        .reset    (periph_reset),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .b        (b),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

    axi4l_reg_file #(
        .NUM_REGS (NUM_REGS)
    ) u_regs (
        .aclk     (aclk),
        .reset    (periph_reset),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_data  (wr_data),
        .wr_strb  (wr_strb),
        .rd_index (rd_index),
        .rd_data  (rd_data)
    );

endmodule

/* hw/axi4l_reg_ctrl.sv */
`timescale 1ns/1ps

module axi4l_reg_ctrl #(
    parameter int NUM_REGS = 8
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  axi4l_pkg::axi4l_aw_t   aw,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  axi4l_pkg::axi4l_w_t    w,
    input  logic                   w_valid,
    output logic                   w_ready,
    output axi4l_pkg::axi4l_b_t    b,
    output logic                   b_valid,
    input  logic                   b_ready,
    input  axi4l_pkg::axi4l_ar_t   ar,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    output axi4l_pkg::axi4l_r_t    r,
    output logic                   r_valid,
    input  logic                   r_ready,
    output logic                   wr_en,
    output axi4l_pkg::reg_index_t  wr_index,
    output axi4l_pkg::axi4l_data_t wr_data,
    output axi4l_pkg::axi4l_strb_t wr_strb,
    output axi4l_pkg::reg_index_t  rd_index,
    input  axi4l_pkg::axi4l_data_t rd_data
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WRITE_RESP,
        READ_RESP
    } state_t;

    state_t               state;
    logic                 aw_held;
    logic                 w_held;
    axi4l_pkg::axi4l_aw_t aw_q;
    axi4l_pkg::axi4l_w_t  w_q;
    axi4l_pkg::axi4l_b_t  b_q;
    axi4l_pkg::axi4l_r_t  r_q;
    logic                 write_ok;
    logic                 read_ok;

    function automatic axi4l_pkg::reg_index_t to_index(input axi4l_pkg::axi4l_addr_t addr);
        return addr[axi4l_pkg::REG_IDX_MSB:axi4l_pkg::REG_IDX_LSB];
    endfunction

    // upper address bits must be zero and the word must exist.
    function automatic logic in_range(input axi4l_pkg::axi4l_addr_t addr);
        return (addr[axi4l_pkg::ADDR_WID-1:axi4l_pkg::REG_IDX_MSB+1] == '0) &&
               (int'(to_index(addr)) < NUM_REGS);
    endfunction

    assign aw_ready = (state == IDLE) && !aw_held;
    assign w_ready  = (state == IDLE) && !w_held;
    assign ar_ready = (state == IDLE) && !aw_held && !w_held;   // writes win.

    assign write_ok = in_range(aw_q.addr) && (to_index(aw_q.addr) != '0);
    assign read_ok  = in_range(ar.addr);

    always_ff @(posedge aclk) begin
        if (reset) begin
            state   <= IDLE;
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (aw_valid && aw_ready) begin
                aw_held <= 1'b1;
            end
            if (w_valid && w_ready) begin
                w_held <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (aw_held && w_held) begin
                        state <= WRITE;
                    end else if (ar_valid && ar_ready) begin
                        state <= READ_RESP;
                    end
                end
                WRITE: begin
                    state   <= WRITE_RESP;
                    aw_held <= 1'b0;
                    w_held  <= 1'b0;
                end
                WRITE_RESP: if (b_ready) state <= IDLE;
                READ_RESP:  if (r_ready) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (aw_valid && aw_ready) begin
            aw_q <= aw;
        end
        if (w_valid && w_ready) begin
            w_q <= w;
        end
        if (state == WRITE) begin
            b_q.resp <= write_ok ? axi4l_pkg::RESP_OKAY : axi4l_pkg::RESP_SLVERR;
        end
        if (ar_valid && ar_ready) begin
            r_q.data <= read_ok ? rd_data : '0;
            r_q.resp <= read_ok ? axi4l_pkg::RESP_OKAY : axi4l_pkg::RESP_SLVERR;
        end
    end

    assign wr_en    = (state == WRITE) && write_ok;
    assign wr_index = to_index(aw_q.addr);
    assign wr_data  = w_q.data;
    assign wr_strb  = w_q.strb;
    assign rd_index = to_index(ar.addr);   // read mux sampled on the ar transfer.

    assign b       = b_q;
    assign b_valid = (state == WRITE_RESP);
    assign r       = r_q;
    assign r_valid = (state == READ_RESP);

endmodule

/* hw/axi4l_reg_file.sv */
`timescale 1ns/1ps

module axi4l_reg_file #(
    parameter int NUM_REGS = 8
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   wr_en,
    input  axi4l_pkg::reg_index_t  wr_index,
    input  axi4l_pkg::axi4l_data_t wr_data,
    input  axi4l_pkg::axi4l_strb_t wr_strb,
    input  axi4l_pkg::reg_index_t  rd_index,
    output axi4l_pkg::axi4l_data_t rd_data
);

    axi4l_pkg::axi4l_data_t regs [1:NUM_REGS-1];   // word 0 is the id register.

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                if (int'(wr_index) == i) begin
                    for (int j = 0; j < axi4l_pkg::STRB_WID; j++) begin
                        if (wr_strb[j]) begin
                            regs[i][j*8 +: 8] <= wr_data[j*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        rd_data = '0;
        if (rd_index == '0) begin
            rd_data = axi4l_pkg::REG_ID_VALUE;
        end else begin
            for (int i = 1; i < NUM_REGS; i++) begin
                if (int'(rd_index) == i) begin
                    rd_data = regs[i];
                end
            end
        end
    end

endmodule

/* hw/axi4l_reg_slice.sv */
`timescale 1ns/1ps

module axi4l_reg_slice #(
    parameter axi4l_pkg::axi4l_slice_mode_t SLICE_MODE = axi4l_pkg::SLICE_FULL
) (
    input  logic                 aclk,
    input  logic                 reset,
    output logic                 periph_reset,
    // controller side
    input  axi4l_pkg::axi4l_aw_t s_aw,
    input  logic                 s_aw_valid,
    output logic                 s_aw_ready,
    input  axi4l_pkg::axi4l_w_t  s_w,
    input  logic                 s_w_valid,
    output logic                 s_w_ready,
    output axi4l_pkg::axi4l_b_t  s_b,
    output logic                 s_b_valid,
    input  logic                 s_b_ready,
    input  axi4l_pkg::axi4l_ar_t s_ar,
    input  logic                 s_ar_valid,
    output logic                 s_ar_ready,
    output axi4l_pkg::axi4l_r_t  s_r,
    output logic                 s_r_valid,
    input  logic                 s_r_ready,
    // peripheral side
    output axi4l_pkg::axi4l_aw_t m_aw,
    output logic                 m_aw_valid,
    input  logic                 m_aw_ready,
    output axi4l_pkg::axi4l_w_t  m_w,
    output logic                 m_w_valid,
    input  logic                 m_w_ready,
    input  axi4l_pkg::axi4l_b_t  m_b,
    input  logic                 m_b_valid,
    output logic                 m_b_ready,
    output axi4l_pkg::axi4l_ar_t m_ar,
    output logic                 m_ar_valid,
    input  logic                 m_ar_ready,
    input  axi4l_pkg::axi4l_r_t  m_r,
    input  logic                 m_r_valid,
    output logic                 m_r_ready
);

    function automatic int reset_stages(input axi4l_pkg::axi4l_slice_mode_t mode);
        case (mode)
            axi4l_pkg::SLICE_BYPASS: return 0;
            axi4l_pkg::SLICE_SLR:    return 3;
            default:                 return 1;
        endcase
    endfunction

    localparam int RST_STAGES = reset_stages(SLICE_MODE);

    ////////////////////////////////////////////////////////////////////////////
    // request channels flow downstream, B and R flow back up

    axi4l_chan_slice #(
        .PAYLOAD_WID ($bits(axi4l_pkg::axi4l_aw_t)),
        .SLICE_MODE  (SLICE_MODE)
    ) u_aw_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (s_aw_valid),
        .in_ready  (s_aw_ready),
        .in_data   (s_aw),
        .out_valid (m_aw_valid),
        .out_ready (m_aw_ready),
        .out_data  (m_aw)
    );

    axi4l_chan_slice #(
        .PAYLOAD_WID ($bits(axi4l_pkg::axi4l_w_t)),
        .SLICE_MODE  (SLICE_MODE)
    ) u_w_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (s_w_valid),
        .in_ready  (s_w_ready),
        .in_data   (s_w),
        .out_valid (m_w_valid),
        .out_ready (m_w_ready),
        .out_data  (m_w)
    );

    axi4l_chan_slice #(
        .PAYLOAD_WID ($bits(axi4l_pkg::axi4l_b_t)),
        .SLICE_MODE  (SLICE_MODE)
    ) u_b_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (m_b_valid),
        .in_ready  (m_b_ready),
        .in_data   (m_b),
        .out_valid (s_b_valid),
        .out_ready (s_b_ready),
        .out_data  (s_b)
    );

    axi4l_chan_slice #(
        .PAYLOAD_WID ($bits(axi4l_pkg::axi4l_ar_t)),
        .SLICE_MODE  (SLICE_MODE)
    ) u_ar_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (s_ar_valid),
        .in_ready  (s_ar_ready),
        .in_data   (s_ar),
        .out_valid (m_ar_valid),
        .out_ready (m_ar_ready),
        .out_data  (m_ar)
    );

    axi4l_chan_slice #(
        .PAYLOAD_WID ($bits(axi4l_pkg::axi4l_r_t)),
        .SLICE_MODE  (SLICE_MODE)
    ) u_r_slice (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (m_r_valid),
        .in_ready  (m_r_ready),
        .in_data   (m_r),
        .out_valid (s_r_valid),
        .out_ready (s_r_ready),
        .out_data  (s_r)
    );

    ////////////////////////////////////////////////////////////////////////////
    // downstream reset pipeline

    generate
        if (RST_STAGES == 0) begin : g_rst_wire
            assign periph_reset = reset;
        end else begin : g_rst_pipe
            logic [RST_STAGES-1:0] rst_pipe;

            always_ff @(posedge aclk) begin
                rst_pipe[0] <= reset;
                for (int i = 1; i < RST_STAGES; i++) begin
                    rst_pipe[i] <= rst_pipe[i-1];
                end
            end

            assign periph_reset = rst_pipe[RST_STAGES-1];
        end
    endgenerate

endmodule

/* hw/axi4l_chan_slice.sv */
`timescale 1ns/1ps

module axi4l_chan_slice #(
    parameter int                           PAYLOAD_WID = 32,
    parameter axi4l_pkg::axi4l_slice_mode_t SLICE_MODE  = axi4l_pkg::SLICE_FULL
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [PAYLOAD_WID-1:0] in_data,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [PAYLOAD_WID-1:0] out_data
);

    generate
        if (SLICE_MODE == axi4l_pkg::SLICE_BYPASS) begin : g_bypass
            assign out_valid = in_valid;
            assign out_data  = in_data;
            assign in_ready  = out_ready;
        end else begin : g_skid
            logic                   main_valid;
            logic                   ready_q;    // low means the skid entry is full.
            logic [PAYLOAD_WID-1:0] main_data;
            logic [PAYLOAD_WID-1:0] skid_data;
            logic                   in_xfer;
            logic                   main_free;

            assign in_xfer   = in_valid && ready_q;
            assign main_free = !main_valid || out_ready;

            always_ff @(posedge aclk) begin
                if (reset) begin
                    main_valid <= 1'b0;
                    ready_q    <= 1'b1;
                end else if (main_free) begin
                    main_valid <= !ready_q || in_xfer;   // skid drains first.
                    ready_q    <= 1'b1;
                end else if (in_xfer) begin
                    ready_q    <= 1'b0;                  // main stalled, park in skid.
                end
            end

            always_ff @(posedge aclk) begin
                if (main_free) begin
                    main_data <= ready_q ? in_data : skid_data;
                end
                if (!main_free && in_xfer) begin
                    skid_data <= in_data;
                end
            end

            assign in_ready  = ready_q;
            assign out_valid = main_valid;
            assign out_data  = main_data;
        end
    endgenerate

endmodule

/* hw/axi4l_pkg.sv */
package axi4l_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and base types

    localparam int ADDR_WID = 32;
    localparam int DATA_WID = 32;
    localparam int STRB_WID = DATA_WID / 8;

    typedef logic [ADDR_WID-1:0] axi4l_addr_t;
    typedef logic [DATA_WID-1:0] axi4l_data_t;
    typedef logic [STRB_WID-1:0] axi4l_strb_t;
    typedef logic [2:0]          axi4l_prot_t;
    typedef logic [1:0]          axi4l_resp_t;

    localparam axi4l_resp_t RESP_OKAY   = 2'd0;
    localparam axi4l_resp_t RESP_SLVERR = 2'd2;

    ////////////////////////////////////////////////////////////////////////////
    // channel payloads

    typedef struct packed {
        axi4l_addr_t addr;
        axi4l_prot_t prot;
    } axi4l_aw_t;

    typedef struct packed {
        axi4l_data_t data;
        axi4l_strb_t strb;
    } axi4l_w_t;

    typedef struct packed {
        axi4l_resp_t resp;
    } axi4l_b_t;

    typedef struct packed {
        axi4l_addr_t addr;
        axi4l_prot_t prot;
    } axi4l_ar_t;

    typedef struct packed {
        axi4l_data_t data;
        axi4l_resp_t resp;
    } axi4l_r_t;

    typedef enum logic [1:0] {
        SLICE_BYPASS,   // wires, no reset delay.
        SLICE_FULL,     // skid buffers, one reset stage.
        SLICE_SLR       // skid buffers, three reset stages.
    } axi4l_slice_mode_t;

    ////////////////////////////////////////////////////////////////////////////
    // register map

    localparam axi4l_data_t REG_ID_VALUE = 32'h4134_0100;
    localparam int          REG_IDX_LSB  = 2;
    localparam int          REG_IDX_MSB  = 9;

    typedef logic [REG_IDX_MSB-REG_IDX_LSB:0] reg_index_t;

endpackage
